/* char_pkg.sv */
// Arena geometry, physics constants and shared types for the character model.
// Velocities carry smooth_shift fraction bits; positions are whole pixels.
`default_nettype none

package char_pkg;

    // ------------------------------------------------
    // word formats
    localparam int pos_w        = 15;         // signed position and velocity
    localparam int smooth_shift = 7;          // fraction bits of a velocity
    localparam int wide_w       = pos_w + 2;  // headroom for sums before clamping
    localparam int charge_w     = 7;

    // ------------------------------------------------
    // arena, measured at the left edge and bottom of the character
    localparam logic signed [pos_w-1:0] arena_min_x = 15'sd130;
    localparam logic signed [pos_w-1:0] arena_max_x = 15'sd558;
    localparam logic signed [pos_w-1:0] floor_y     = 15'sd10;
    localparam logic signed [pos_w-1:0] init_x      = 15'sd344;
    localparam logic signed [pos_w-1:0] init_y      = 15'sd20;

    // physics, velocities in 1/128 pixel per step
    localparam logic signed [pos_w-1:0] max_vel    = 15'sd5120;
    localparam logic signed [pos_w-1:0] gravity    = -15'sd128;
    localparam logic signed [pos_w-1:0] walk_step  = 15'sd3;    // whole pixels
    localparam logic signed [pos_w-1:0] jump_vel_x = 15'sd256;
    localparam logic signed [pos_w-1:0] jump_vel_y = 15'sd640;

    // jump boost per charge quarter
    localparam logic signed [pos_w-1:0] boost_0 = 15'sd320;
    localparam logic signed [pos_w-1:0] boost_1 = 15'sd480;
    localparam logic signed [pos_w-1:0] boost_2 = 15'sd960;
    localparam logic signed [pos_w-1:0] boost_3 = 15'sd1600;

    localparam logic [charge_w-1:0] charge_max = 7'd100;
    localparam logic [charge_w-1:0] charge_inc = 7'd10;

    // ------------------------------------------------
    typedef enum logic [2:0] {
        idle,
        walk_left,
        walk_right,
        charge,
        jump,
        bounce,
        land
    } motion_state_e;

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
        logic jump_rise;    // one cycle on press
    } btn_t;

    typedef struct packed {
        logic on_ground;
        logic hit_side;
        logic landed;
    } contact_t;

    typedef struct packed {
        motion_state_e           state;
        logic signed [1:0]       face;   // +1 right, -1 left
        logic signed [pos_w-1:0] boost;
    } motion_cmd_t;

    typedef struct packed {
        logic signed [pos_w-1:0] pos_x;
        logic signed [pos_w-1:0] pos_y;
        logic signed [pos_w-1:0] vel_x;
        logic signed [pos_w-1:0] vel_y;
        motion_state_e           state;
        logic signed [1:0]       face;
        contact_t                contact;
    } char_report_t;

endpackage

`default_nettype wire

/* btn_sampler.sv */
// Buttons are taken as already synchronous to sys_clk; only one register stage.
// A tick seen while busy is high is lost, not queued.
`default_nettype none

module btn_sampler (
    input  wire            sys_clk,
    input  wire            sys_rst_n,
    input  wire            char_tick,
    input  wire            btn_left,
    input  wire            btn_right,
    input  wire            btn_jump,
    input  wire            busy,
    output char_pkg::btn_t btns,
    output logic           step
);

    logic left_q;
    logic right_q;
    logic jump_q;
    logic jump_qq;   // previous jump level for edge detect
    logic tick_q;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            left_q  <= 1'b0;
            right_q <= 1'b0;
            jump_q  <= 1'b0;
            jump_qq <= 1'b0;
            tick_q  <= 1'b0;
        end else begin
            left_q  <= btn_left;
            right_q <= btn_right;
            jump_q  <= btn_jump;
            jump_qq <= jump_q;
            tick_q  <= char_tick;
        end
    end

    assign btns = '{left:      left_q,
                    right:     right_q,
                    jump:      jump_q,
                    jump_rise: jump_q & ~jump_qq};

    // drop the step while the report side holds a sample
    assign step = tick_q & ~busy;

endmodule

`default_nettype wire

/* motion_fsm.sv */
// Motion FSM; cmd carries the state and face being entered on this step,
// so physics applies a walk or jump impulse on the same step it is chosen.
`default_nettype none

module motion_fsm (
    input  wire                   sys_clk,
    input  wire                   sys_rst_n,
    input  wire                   step,
    input  wire char_pkg::btn_t   btns,
    input  wire char_pkg::contact_t contact,
    output char_pkg::motion_cmd_t cmd
);

    char_pkg::motion_state_e state;
    char_pkg::motion_state_e next_state;
    logic signed [1:0]                 face;
    logic signed [1:0]                 next_face;
    logic                              armed;       // jump pressed on ground
    logic [char_pkg::charge_w-1:0]     count;
    logic signed [char_pkg::pos_w-1:0] boost;
    logic                              charge_full;

    assign charge_full = (count >= char_pkg::charge_max);

    // ------------------------------------------------
    // next state, contacts take priority
    always_comb begin
        next_state = char_pkg::idle;
        if (contact.landed) begin
            next_state = char_pkg::land;
        end else if (contact.hit_side) begin
            next_state = char_pkg::bounce;
        end else begin
            case (state)
                char_pkg::idle, char_pkg::walk_left, char_pkg::walk_right: begin
                    if (!contact.on_ground) next_state = char_pkg::idle;   // airborne
                    else if (btns.left)     next_state = char_pkg::walk_left;
                    else if (btns.right)    next_state = char_pkg::walk_right;
                    else if (armed)         next_state = char_pkg::charge;
                end
                char_pkg::charge: begin
                    if (!btns.jump || charge_full) next_state = char_pkg::jump;
                    else                           next_state = char_pkg::charge;
                end
                default: next_state = char_pkg::idle;   // jump, bounce, land
            endcase
        end
    end

    always_comb begin
        if (contact.hit_side)                      next_face = -face;
        else if (next_state == char_pkg::walk_left)  next_face = 2'sb11;
        else if (next_state == char_pkg::walk_right) next_face = 2'sb01;
        else                                       next_face = face;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= char_pkg::idle;
            face  <= 2'sb01;
        end else if (step) begin
            state <= next_state;
            face  <= next_face;
        end
    end

    // arming runs every clock, a press between ticks is not missed
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)                              armed <= 1'b0;
        else if (btns.jump_rise && contact.on_ground) armed <= 1'b1;
        else if (state == char_pkg::jump)            armed <= 1'b0;
    end

    // ------------------------------------------------
    // charge counter and boost lookup
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            count <= 7'd1;
        end else if (step) begin
            if (state == char_pkg::charge)    count <= count + char_pkg::charge_inc;
            else if (state == char_pkg::jump) count <= 7'd1;
        end
    end

    always_comb begin
        if (count <= (char_pkg::charge_max >> 2))      boost = char_pkg::boost_0;
        else if (count <= (char_pkg::charge_max >> 1)) boost = char_pkg::boost_1;
        else if (count <= (char_pkg::charge_max >> 1) + (char_pkg::charge_max >> 2))
            boost = char_pkg::boost_2;
        else                                           boost = char_pkg::boost_3;
    end

    assign cmd = '{state: next_state, face: next_face, boost: boost};

endmodule

`default_nettype wire

/* physics_integrator.sv */
// One physics step per qualified tick; velocity saturates at +/- max_vel.
// No impact point is computed, a landing simply stops on the floor line.
`default_nettype none

module physics_integrator (
    input  wire                          sys_clk,
    input  wire                          sys_rst_n,
    input  wire                          step,
    input  wire char_pkg::motion_cmd_t   cmd,
    input  wire char_pkg::contact_t      contact,
    output logic signed [char_pkg::pos_w-1:0] pos_x,
    output logic signed [char_pkg::pos_w-1:0] pos_y,
    output logic signed [char_pkg::pos_w-1:0] vel_x,
    output logic signed [char_pkg::pos_w-1:0] vel_y
);

    logic signed [char_pkg::pos_w-1:0]  jump_x;   // horizontal jump magnitude
    logic signed [char_pkg::pos_w-1:0]  imp_x;
    logic signed [char_pkg::pos_w-1:0]  imp_y;
    logic signed [char_pkg::pos_w-1:0]  grav;
    logic signed [char_pkg::pos_w-1:0]  walk;
    logic signed [char_pkg::wide_w-1:0] vx_sum;
    logic signed [char_pkg::wide_w-1:0] vy_sum;
    logic signed [char_pkg::wide_w-1:0] x_sum;
    logic signed [char_pkg::wide_w-1:0] y_sum;
    logic signed [char_pkg::pos_w-1:0]  vx_next;
    logic signed [char_pkg::pos_w-1:0]  vy_next;
    logic signed [char_pkg::pos_w-1:0]  x_next;
    logic signed [char_pkg::pos_w-1:0]  y_next;

    function automatic logic signed [char_pkg::pos_w-1:0] clamp_vel(
        input logic signed [char_pkg::wide_w-1:0] v
    );
        if (v > char_pkg::max_vel)       return char_pkg::max_vel;
        else if (v < -char_pkg::max_vel) return -char_pkg::max_vel;
        return v[char_pkg::pos_w-1:0];
    endfunction

    // ------------------------------------------------
    // impulses for this step
    always_comb begin
        jump_x = char_pkg::jump_vel_x + (cmd.boost >>> 1);
        imp_x  = '0;
        imp_y  = '0;
        if (cmd.state == char_pkg::jump) begin
            imp_x = (cmd.face < 0) ? -jump_x : jump_x;
            imp_y = char_pkg::jump_vel_y + cmd.boost;
        end
        grav = contact.on_ground ? '0 : char_pkg::gravity;
        case (cmd.state)
            char_pkg::walk_left:  walk = -char_pkg::walk_step;
            char_pkg::walk_right: walk = char_pkg::walk_step;
            default:              walk = '0;
        endcase
    end

    // velocity then position, position uses the new velocity
    always_comb begin
        vx_sum = contact.hit_side ? -vel_x : vel_x + imp_x;   // bounce reverses x
        vy_sum = vel_y + imp_y + grav;
        if (contact.landed) begin
            vx_next = '0;
            vy_next = '0;
        end else begin
            vx_next = clamp_vel(vx_sum);
            vy_next = clamp_vel(vy_sum);
        end

        x_sum = pos_x + walk + (vx_next >>> char_pkg::smooth_shift);
        y_sum = pos_y + (vy_next >>> char_pkg::smooth_shift);

        if (x_sum < char_pkg::arena_min_x)      x_next = char_pkg::arena_min_x;
        else if (x_sum > char_pkg::arena_max_x) x_next = char_pkg::arena_max_x;
        else                                    x_next = x_sum[char_pkg::pos_w-1:0];

        if (y_sum < char_pkg::floor_y) y_next = char_pkg::floor_y;   // snap to floor
        else                           y_next = y_sum[char_pkg::pos_w-1:0];
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pos_x <= char_pkg::init_x;
            pos_y <= char_pkg::init_y;
            vel_x <= '0;
            vel_y <= '0;
        end else if (step) begin
            pos_x <= x_next;
            pos_y <= y_next;
            vel_x <= vx_next;
            vel_y <= vy_next;
        end
    end

endmodule

`default_nettype wire

/* contact_detector.sv */
// Contacts against the two side walls and the floor only, no obstacles.
`default_nettype none

module contact_detector (
    input  wire signed [char_pkg::pos_w-1:0] pos_x,
    input  wire signed [char_pkg::pos_w-1:0] pos_y,
    input  wire signed [char_pkg::pos_w-1:0] vel_x,
    input  wire signed [char_pkg::pos_w-1:0] vel_y,
    output char_pkg::contact_t               contact
);

    logic at_left;       // pinned against the left wall
    logic at_right;
    logic moving_left;
    logic moving_right;
    logic on_floor;
    logic falling;

    // ------------------------------------------------
    // position against arena limits
    assign at_left  = (pos_x <= char_pkg::arena_min_x);
    assign at_right = (pos_x >= char_pkg::arena_max_x);
    assign on_floor = (pos_y == char_pkg::floor_y);

    // direction of travel
    assign moving_left  = (vel_x < 0);
    assign moving_right = (vel_x > 0);
    assign falling      = (vel_y < 0);

    // a wall only counts when the speed still points into it
    assign contact = '{on_ground: on_floor,
                       hit_side:  (at_left && moving_left) || (at_right && moving_right),
                       landed:    on_floor && falling};

endmodule

`default_nettype wire

/* state_reporter.sv */
// One status sample per step, held until taken under valid/ready.
// Ticks must be at least 3 cycles apart so a load never meets a pending sample.
`default_nettype none

module state_reporter (
    input  wire                              sys_clk,
    input  wire                              sys_rst_n,
    input  wire                              step,
    input  wire signed [char_pkg::pos_w-1:0] pos_x,
    input  wire signed [char_pkg::pos_w-1:0] pos_y,
    input  wire signed [char_pkg::pos_w-1:0] vel_x,
    input  wire signed [char_pkg::pos_w-1:0] vel_y,
    input  wire char_pkg::motion_cmd_t       cmd,
    input  wire char_pkg::contact_t          contact,
    input  wire                              report_ready,
    output char_pkg::char_report_t           report,
    output logic                             report_valid,
    output logic                             busy
);

    logic                    load_q;    // step delayed, physics has settled
    char_pkg::motion_state_e state_q;
    logic signed [1:0]       face_q;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) load_q <= 1'b0;
        else            load_q <= step;
    end

    // state and face entered on this step
    always_ff @(posedge sys_clk) begin
        if (step) begin
            state_q <= cmd.state;
            face_q  <= cmd.face;
        end
    end

    // ------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)        report_valid <= 1'b0;
        else if (load_q)       report_valid <= 1'b1;
        else if (report_ready) report_valid <= 1'b0;   // sample taken
    end

    always_ff @(posedge sys_clk) begin
        if (load_q) begin
            report <= '{pos_x: pos_x, pos_y: pos_y, vel_x: vel_x, vel_y: vel_y,
                        state: state_q, face: face_q, contact: contact};
        end
    end

    assign busy = load_q | (report_valid & ~report_ready);

endmodule

`default_nettype wire

/* character_top.sv */
// Platformer character in a walled arena, one physics step per char_tick.
// Ticks at least 3 cycles apart; ticks during output back-pressure are dropped.
`default_nettype none

module character_top (
    input  wire                    sys_clk,
    input  wire                    sys_rst_n,
    input  wire                    char_tick,
    input  wire                    btn_left,
    input  wire                    btn_right,
    input  wire                    btn_jump,
    input  wire                    report_ready,
    output logic                   report_valid,
    output char_pkg::char_report_t report
);

    char_pkg::btn_t                    btns;
    char_pkg::contact_t                contact;
    char_pkg::motion_cmd_t             cmd;
    logic                              step;
    logic                              busy;
    logic signed [char_pkg::pos_w-1:0] pos_x;
    logic signed [char_pkg::pos_w-1:0] pos_y;
    logic signed [char_pkg::pos_w-1:0] vel_x;
    logic signed [char_pkg::pos_w-1:0] vel_y;

    // ------------------------------------------------
    // input side
    btn_sampler btn_sampler_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .char_tick (char_tick),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_jump  (btn_jump),
        .busy      (busy),
        .btns      (btns),
        .step      (step)
    );

    // ------------------------------------------------
    // motion and physics
    motion_fsm motion_fsm_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step      (step),
        .btns      (btns),
        .contact   (contact),
        .cmd       (cmd)
    );

    physics_integrator physics_integrator_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .step      (step),
        .cmd       (cmd),
        .contact   (contact),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .vel_x     (vel_x),
        .vel_y     (vel_y)
    );

    contact_detector contact_detector_i (
        .pos_x   (pos_x),
        .pos_y   (pos_y),
        .vel_x   (vel_x),
        .vel_y   (vel_y),
        .contact (contact)
    );

    // output side
    state_reporter state_reporter_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .step         (step),
        .pos_x        (pos_x),
        .pos_y        (pos_y),
        .vel_x        (vel_x),
        .vel_y        (vel_y),
        .cmd          (cmd),
        .contact      (contact),
        .report_ready (report_ready),
        .report       (report),
        .report_valid (report_valid),
        .busy         (busy)
    );

endmodule

`default_nettype wire

/* tb_vectors.svh */
// Stimulus table for tb_character_top, rows applied in order from reset.
// Expected fields apply to the last sample of a row, or to the first one meeting the wait.
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct {
    logic                    left;
    logic                    right;
    logic                    jump;
    int                      ticks;       // tick count, or limit for a wait
    logic                    rnd;         // random report_ready
    int                      wait_kind;   // 0 last sample, 1 until pos_y, 2 until state
    char_pkg::motion_state_e state;
    int                      pos_x;
    int                      pos_y;
    int                      vel_x;
    int                      vel_y;
    int                      face;
    char_pkg::contact_t      contact;     // on_ground, hit_side, landed
} vec_t;

// columns: left right jump ticks rnd wait state x y vx vy face contact
vec_t vecs [35] = '{
    '{0, 0, 0, 10,  0, 1, char_pkg::idle,       344, 10,  0,    -512,  1, 3'b101},
    '{0, 0, 0, 1,   0, 0, char_pkg::land,       344, 10,  0,    0,     1, 3'b100},
    '{0, 0, 0, 1,   0, 0, char_pkg::idle,       344, 10,  0,    0,     1, 3'b100},
    '{1, 0, 0, 1,   0, 0, char_pkg::walk_left,  341, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   0, 0, char_pkg::walk_left,  338, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   0, 0, char_pkg::walk_left,  335, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   0, 0, char_pkg::walk_left,  332, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   0, 0, char_pkg::walk_left,  329, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 1, 1,   0, 0, char_pkg::charge,     329, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 1, 2,   0, 0, char_pkg::charge,     329, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 0, 1,   0, 0, char_pkg::jump,       325, 17,  -416, 960,  -1, 3'b000},
    '{0, 0, 0, 20,  0, 1, char_pkg::idle,       269, 10,  -416, -832, -1, 3'b101},
    '{0, 0, 0, 1,   0, 0, char_pkg::land,       269, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 0, 1,   0, 0, char_pkg::idle,       269, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 1, 1,   0, 0, char_pkg::charge,     269, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 1, 10,  0, 0, char_pkg::charge,     269, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 1, 1,   0, 0, char_pkg::jump,       260, 27,  -1056, 2240, -1, 3'b000},
    '{0, 0, 0, 30,  0, 2, char_pkg::bounce,     138, 163, 1056, 192,   1, 3'b000},
    '{0, 0, 0, 30,  0, 1, char_pkg::idle,       282, 10,  1056, -2112, 1, 3'b101},
    '{0, 0, 0, 1,   0, 0, char_pkg::land,       282, 10,  0,    0,     1, 3'b100},
    '{0, 0, 0, 1,   0, 0, char_pkg::idle,       282, 10,  0,    0,     1, 3'b100},
    '{0, 1, 0, 150, 0, 0, char_pkg::walk_right, 558, 10,  0,    0,     1, 3'b100},
    '{0, 0, 1, 1,   0, 0, char_pkg::charge,     558, 10,  0,    0,     1, 3'b100},
    '{0, 0, 0, 1,   0, 0, char_pkg::jump,       558, 17,  416,  960,   1, 3'b010},
    '{0, 0, 0, 1,   0, 0, char_pkg::bounce,     554, 23,  -416, 832,  -1, 3'b000},
    '{0, 0, 0, 20,  0, 1, char_pkg::idle,       502, 10,  -416, -832, -1, 3'b101},
    '{0, 0, 0, 1,   0, 0, char_pkg::land,       502, 10,  0,    0,    -1, 3'b100},
    '{0, 0, 0, 1,   0, 0, char_pkg::idle,       502, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   1, 0, char_pkg::walk_left,  499, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   1, 0, char_pkg::walk_left,  496, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   1, 0, char_pkg::walk_left,  493, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   1, 0, char_pkg::walk_left,  490, 10,  0,    0,    -1, 3'b100},
    '{1, 0, 0, 1,   1, 0, char_pkg::walk_left,  487, 10,  0,    0,    -1, 3'b100},
    '{0, 1, 0, 1,   1, 0, char_pkg::walk_right, 490, 10,  0,    0,     1, 3'b100},
    '{0, 0, 0, 1,   1, 0, char_pkg::idle,       490, 10,  0,    0,     1, 3'b100}
};

`endif

/* tb_character_top.sv */
// Runs the table in tb_vectors.svh against character_top with one sample per tick.
// Random ready rows also send one extra tick during a stall, which must be dropped.
`default_nettype none

module tb_character_top;

    localparam int clk_period = 100;

    logic                   sys_clk;
    logic                   sys_rst_n;
    logic                   char_tick;
    logic                   btn_left;
    logic                   btn_right;
    logic                   btn_jump;
    logic                   report_ready;
    logic                   report_valid;
    char_pkg::char_report_t report;
    int                     errors;

    `include "tb_vectors.svh"

    character_top dut_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .char_tick    (char_tick),
        .btn_left     (btn_left),
        .btn_right    (btn_right),
        .btn_jump     (btn_jump),
        .report_ready (report_ready),
        .report_valid (report_valid),
        .report       (report)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(clk_period / 2) sys_clk = ~sys_clk;
    end

    function automatic int total_ticks();
        int t;
        t = 0;
        foreach (vecs[i]) t += vecs[i].ticks;
        return t;
    endfunction

    // --------------------------------------------------
    // compare tasks
    task automatic check_state(input string name, input char_pkg::motion_state_e got,
                               input char_pkg::motion_state_e exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic signed [char_pkg::pos_w-1:0] got,
                              input logic signed [char_pkg::pos_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_contact(input string name, input char_pkg::contact_t got,
                                 input char_pkg::contact_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_sample(input char_pkg::char_report_t s, input vec_t v);
        check_state("report.state", s.state, v.state);
        check_word("report.pos_x", s.pos_x, v.pos_x);
        check_word("report.pos_y", s.pos_y, v.pos_y);
        check_word("report.vel_x", s.vel_x, v.vel_x);
        check_word("report.vel_y", s.vel_y, v.vel_y);
        check_word("report.face", s.face, v.face);   // sign extended
        check_contact("report.contact", s.contact, v.contact);
    endtask

    // --------------------------------------------------
    // sends one tick and returns the sample taken over valid/ready
    task automatic send_tick(input logic rnd, output char_pkg::char_report_t s);
        logic                   got;
        logic                   extra_sent;
        logic                   stalled;
        int                     hold_low;
        int                     cyc;
        char_pkg::char_report_t held;
        got        = 1'b0;
        extra_sent = 1'b0;
        stalled    = 1'b0;
        hold_low   = 0;
        cyc        = 0;
        held       = '0;
        repeat (2) @(negedge sys_clk);   // let a jump press arm first
        char_tick = 1'b1;
        while (!got) begin
            @(negedge sys_clk);
            cyc++;
            char_tick = 1'b0;
            if (stalled && !report_valid) begin
                errors++;
                $display("report_valid fell at %0t before the sample was taken", $time);
            end else if (stalled && report !== held) begin
                errors++;
                $display("report changed at %0t while the output was stalled", $time);
            end
            if (hold_low > 0) begin
                report_ready = 1'b0;
                hold_low--;
            end else begin
                report_ready = rnd ? $urandom_range(1, 0) : 1'b1;
            end
            // a tick during a stall must be swallowed by busy
            if (rnd && report_valid && !report_ready && !extra_sent) begin
                char_tick  = 1'b1;
                extra_sent = 1'b1;
                hold_low   = 1;
            end
            stalled = report_valid && !report_ready;
            held    = report;
            if (report_valid && report_ready) begin
                got = 1'b1;
                s   = report;     // transfers on the next rising edge
            end
        end
        while (cyc < 6) begin
            @(negedge sys_clk);
            cyc++;
            report_ready = 1'b1;
        end
    endtask

    task automatic run_row(input vec_t v, input int idx);
        char_pkg::char_report_t s;
        logic                   met;
        int                     n;
        met       = 1'b0;
        n         = 0;
        s         = '0;
        btn_left  = v.left;
        btn_right = v.right;
        btn_jump  = v.jump;
        while (n < v.ticks && !met) begin
            send_tick(v.rnd, s);
            n++;
            case (v.wait_kind)
                1:       met = (s.pos_y == v.pos_y);
                2:       met = (s.state == v.state);
                default: met = (n == v.ticks);
            endcase
        end
        if (!met) begin
            errors++;
            $display("row %0d: expected sample did not come within %0d ticks", idx, v.ticks);
        end else begin
            check_sample(s, v);
        end
    endtask

    // --------------------------------------------------
    initial begin
        void'($urandom(63));
        errors       = 0;
        sys_rst_n    = 1'b0;
        char_tick    = 1'b0;
        btn_left     = 1'b0;
        btn_right    = 1'b0;
        btn_jump     = 1'b0;
        report_ready = 1'b1;
        repeat (4) @(negedge sys_clk);
        sys_rst_n = 1'b1;
        foreach (vecs[i]) run_row(vecs[i], i);
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog allows about 8 cycles per tick plus slack for stalls
    initial begin
        #((total_ticks() * 8 + 2000) * clk_period);
        $display("run timed out, the DUT stopped delivering samples");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
char_pkg.sv
btn_sampler.sv
motion_fsm.sv
physics_integrator.sv
contact_detector.sv
state_reporter.sv
character_top.sv
tb_character_top.sv

/* Bender.yml */
package:
  name: character_top

sources:
  - files:
      - char_pkg.sv
      - btn_sampler.sv
      - motion_fsm.sv
      - physics_integrator.sv
      - contact_detector.sv
      - state_reporter.sv
      - character_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_character_top.sv
